/* logic/chanRespIf.sv */
`timescale 1ns/1ps
`default_nettype none

// Response path of one channel towards the arbiter
interface chanRespIf import memCtrlPkg::*; ();

    // Beat presented by the channel, held until granted
    logic        beatValid;
    logic        beatLast;
    dataWord_t   beatData;
    reqId_t      beatId;

    // Pending work, used for the depth comparison
    queueDepth_t depth;

    // Beat moves when valid and grant are both high
    logic        grant;

    // Channel side
    modport chan (
        output beatValid, beatLast, beatData, beatId, depth,
        input  grant
    );

    // Arbiter side
    modport arb (
        input  beatValid, beatLast, beatData, beatId, depth,
        output grant
    );

endinterface

`default_nettype wire

/* logic/channelStore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memCtrl_macros.svh"

module channelStore import memCtrlPkg::*; #(
    parameter int chanIdx = 0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      reqValid,
    input  logic      reqWrite,
    input  memAddr_t  reqAddr,
    input  reqId_t    reqId,
    input  dataWord_t reqData,
    output logic      ackValid,
    output reqId_t    ackId,
    output logic      full,
    chanRespIf.chan   resp
);
    localparam int NumWords = 1 << `MC_WORD_ADDR_W;

    // ------------------------------------------------------------------
    // Request dispatch
    // ------------------------------------------------------------------

    dataWord_t   mem [NumWords];
    logic        claim;
    wordAddr_t   reqWordAddr;

    // Channel bit sits above the word address
    assign claim       = reqValid & (reqAddr[`MC_WORD_ADDR_W] == 1'(chanIdx));
    assign reqWordAddr = reqAddr[`MC_WORD_ADDR_W-1:0];

    // Write lands at the sampling edge
    always_ff @(posedge clk) begin
        if (claim && reqWrite) begin
            mem[reqWordAddr] <= reqData;
        end
    end

    // Ack one cycle after the write strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ackValid <= 1'b0;
        end else begin
            ackValid <= claim & reqWrite;
        end
    end

    // Id of the last write claimed by this channel
    always_ff @(posedge clk) begin
        if (claim && reqWrite) begin
            ackId <= reqId;
        end
    end

    // ------------------------------------------------------------------
    // Pending reads
    // ------------------------------------------------------------------

    wordAddr_t   headAddr;
    reqId_t      headId;
    logic        qEmpty;
    queueDepth_t qCount;
    logic        pop;

    readQueue i_readQueue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (claim & ~reqWrite),
        .pushAddr (reqWordAddr),
        .pushId   (reqId),
        .pop      (pop),
        .headAddr (headAddr),
        .headId   (headId),
        .empty    (qEmpty),
        .full     (full),
        .count    (qCount)
    );

    // ------------------------------------------------------------------
    // Burst engine
    // ------------------------------------------------------------------

    logic      active;
    beatIdx_t  beatIdx;
    wordAddr_t burstAddr;
    reqId_t    burstId;
    logic      beatFire;

    // Next read starts only once the engine has gone idle
    assign pop      = ~active & ~qEmpty;
    assign beatFire = active & resp.grant;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            beatIdx <= '0;
        end else if (pop) begin
            active  <= 1'b1;
            beatIdx <= '0;
        end else if (beatFire) begin
            if (resp.beatLast) begin
                active <= 1'b0;
            end
            beatIdx <= beatIdx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            burstAddr <= headAddr;
            burstId   <= headId;
        end
    end

    // Words follow the start address and wrap inside the channel
    assign resp.beatValid = active;
    assign resp.beatLast  = active & (beatIdx == beatIdx_t'(`MC_BURST_LEN - 1));
    assign resp.beatData  = mem[wordAddr_t'(burstAddr + wordAddr_t'(beatIdx))];
    assign resp.beatId    = burstId;

    // Burst in flight counts as one more pending read
    assign resp.depth = queueDepth_t'(qCount + queueDepth_t'(active));

endmodule

`default_nettype wire

/* logic/memCtrlPkg.sv */
`default_nettype none

`include "memCtrl_macros.svh"

package memCtrlPkg;

    // One data word of the store
    typedef logic [`MC_DATA_W-1:0] dataWord_t;

    // Request id, echoed on ack and read beats
    typedef logic [`MC_ID_W-1:0] reqId_t;

    // Word address inside a channel
    typedef logic [`MC_WORD_ADDR_W-1:0] wordAddr_t;

    // Full address, top bit picks the channel
    typedef logic [`MC_WORD_ADDR_W:0] memAddr_t;

    // Queued reads plus one burst in flight
    typedef logic [$clog2(`MC_QUEUE_DEPTH + 2)-1:0] queueDepth_t;

    // Beat position within a burst
    typedef logic [$clog2(`MC_BURST_LEN)-1:0] beatIdx_t;

    // Consecutive bursts served, saturates at the limit
    typedef logic [$clog2(`MC_SERVE_LIMIT + 1)-1:0] serveCnt_t;

    // Channel currently owning the response path
    typedef enum logic {ServeCh0, ServeCh1} respState_t;

endpackage

`default_nettype wire

/* logic/memCtrlTop.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrlTop import memCtrlPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       reqValid,
    input  logic       reqWrite,
    input  memAddr_t   reqAddr,
    input  reqId_t     reqId,
    input  dataWord_t  reqData,
    output logic       respValid,
    output logic       respLast,
    output dataWord_t  respData,
    output reqId_t     respId,
    output logic       ackValid,
    output reqId_t     ackId,
    output logic [1:0] chFull
);
    // Per-channel response buses
    chanRespIf ch0Resp ();
    chanRespIf ch1Resp ();

    // Ack path from each channel
    logic   ch0AckValid;
    logic   ch1AckValid;
    reqId_t ch0AckId;
    reqId_t ch1AckId;

    // Arbiter and counter handshake
    logic servedLast;
    logic otherDeeper;
    logic switchNow;
    logic limitHit;

    // ------------------------------------------------------------------
    // Channels
    // ------------------------------------------------------------------

    channelStore #(.chanIdx(0)) i_ch0Store (
        .clk (clk), .rst_n (rst_n),
        .reqValid (reqValid), .reqWrite (reqWrite), .reqAddr (reqAddr),
        .reqId (reqId), .reqData (reqData),
        .ackValid (ch0AckValid), .ackId (ch0AckId),
        .full (chFull[0]), .resp (ch0Resp.chan)
    );

    channelStore #(.chanIdx(1)) i_ch1Store (
        .clk (clk), .rst_n (rst_n),
        .reqValid (reqValid), .reqWrite (reqWrite), .reqAddr (reqAddr),
        .reqId (reqId), .reqData (reqData),
        .ackValid (ch1AckValid), .ackId (ch1AckId),
        .full (chFull[1]), .resp (ch1Resp.chan)
    );

    // ------------------------------------------------------------------
    // Response arbitration
    // ------------------------------------------------------------------

    respArbiter i_respArbiter (
        .clk (clk), .rst_n (rst_n),
        .ch0 (ch0Resp.arb), .ch1 (ch1Resp.arb),
        .ch0AckValid (ch0AckValid), .ch1AckValid (ch1AckValid),
        .ch0AckId (ch0AckId), .ch1AckId (ch1AckId),
        .limitHit (limitHit),
        .servedLast (servedLast), .otherDeeper (otherDeeper), .switchNow (switchNow),
        .respValid (respValid), .respLast (respLast),
        .respData (respData), .respId (respId),
        .ackValid (ackValid), .ackId (ackId)
    );

    serveCounter i_serveCounter (
        .clk (clk), .rst_n (rst_n),
        .servedLast (servedLast), .otherDeeper (otherDeeper),
        .switchNow (switchNow), .limitHit (limitHit)
    );

endmodule

`default_nettype wire

/* logic/memCtrl_macros.svh */
`ifndef MEMCTRL_MACROS_SVH
`define MEMCTRL_MACROS_SVH

// ------------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------------

// Width of one stored word
`define MC_DATA_W        32
// Request id width
`define MC_ID_W          4
// Word address inside one channel, 16 words each
`define MC_WORD_ADDR_W   4

// ------------------------------------------------------------------
// Channel behaviour
// ------------------------------------------------------------------

// Beats returned per read
`define MC_BURST_LEN     4
// Pending reads held per channel
`define MC_QUEUE_DEPTH   4
// Bursts from one channel before the other one gets a turn
`define MC_SERVE_LIMIT   4

`endif

/* logic/readQueue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memCtrl_macros.svh"

module readQueue import memCtrlPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push,
    input  wordAddr_t   pushAddr,
    input  reqId_t      pushId,
    input  logic        pop,
    output wordAddr_t   headAddr,
    output reqId_t      headId,
    output logic        empty,
    output logic        full,
    output queueDepth_t count
);
    localparam int PtrW = $clog2(`MC_QUEUE_DEPTH);

    // Entry storage
    wordAddr_t        addrMem [`MC_QUEUE_DEPTH];
    reqId_t           idMem   [`MC_QUEUE_DEPTH];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic             doPush;
    logic             doPop;

    // Push into a full queue is dropped
    assign doPush = push & ~full;
    assign doPop  = pop & ~empty;

    assign empty    = (count == '0);
    assign full     = (count == queueDepth_t'(`MC_QUEUE_DEPTH));
    assign headAddr = addrMem[rdPtr];
    assign headId   = idMem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            addrMem[wrPtr] <= pushAddr;
            idMem[wrPtr]   <= pushId;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PtrW'(`MC_QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrW'(`MC_QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/respArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module respArbiter import memCtrlPkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    chanRespIf.arb    ch0,
    chanRespIf.arb    ch1,
    input  logic      ch0AckValid,
    input  logic      ch1AckValid,
    input  reqId_t    ch0AckId,
    input  reqId_t    ch1AckId,
    input  logic      limitHit,
    output logic      servedLast,
    output logic      otherDeeper,
    output logic      switchNow,
    output logic      respValid,
    output logic      respLast,
    output dataWord_t respData,
    output reqId_t    respId,
    output logic      ackValid,
    output reqId_t    ackId
);
    respState_t  state;
    respState_t  nextState;
    logic        onCh1;
    logic        servedValid;
    logic        servedBeatLast;
    dataWord_t   servedData;
    reqId_t      servedId;
    queueDepth_t servedDepth;
    queueDepth_t otherDepth;
    logic        atBoundary;

    assign onCh1 = (state == ServeCh1);

    // ------------------------------------------------------------------
    // Served and waiting channel views
    // ------------------------------------------------------------------

    always_comb begin
        if (onCh1) begin
            servedValid    = ch1.beatValid;
            servedBeatLast = ch1.beatLast;
            servedData     = ch1.beatData;
            servedId       = ch1.beatId;
            servedDepth    = ch1.depth;
            otherDepth     = ch0.depth;
        end else begin
            servedValid    = ch0.beatValid;
            servedBeatLast = ch0.beatLast;
            servedData     = ch0.beatData;
            servedId       = ch0.beatId;
            servedDepth    = ch0.depth;
            otherDepth     = ch1.depth;
        end
    end

    // Only the owner moves, the other one holds its beat
    assign ch0.grant = ~onCh1 & ch0.beatValid;
    assign ch1.grant = onCh1 & ch1.beatValid;

    // ------------------------------------------------------------------
    // Switch decision
    // ------------------------------------------------------------------

    // Idle or last beat, never inside a burst
    assign atBoundary  = ~servedValid | servedBeatLast;
    assign servedLast  = servedValid & servedBeatLast;
    assign otherDeeper = (otherDepth > servedDepth);

    // Deeper rival wins, or the limit forces a turn if it has work
    assign switchNow = atBoundary & (otherDeeper | (limitHit & (otherDepth != '0)));

    assign nextState = switchNow ? (onCh1 ? ServeCh0 : ServeCh1) : state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ServeCh0;
        end else begin
            state <= nextState;
        end
    end

    // ------------------------------------------------------------------
    // Output muxes
    // ------------------------------------------------------------------

    assign respValid = servedValid;
    assign respLast  = servedLast;
    assign respData  = servedData;
    assign respId    = servedId;

    // At most one ack per cycle since requests arrive one at a time
    assign ackValid = ch0AckValid | ch1AckValid;
    assign ackId    = ch1AckValid ? ch1AckId : ch0AckId;

endmodule

`default_nettype wire

/* logic/serveCounter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memCtrl_macros.svh"

module serveCounter import memCtrlPkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic servedLast,
    input  logic otherDeeper,
    input  logic switchNow,
    output logic limitHit
);
    // Bursts completed in a row by the served channel
    serveCnt_t cnt;

    assign limitHit = (cnt == serveCnt_t'(`MC_SERVE_LIMIT));

    // ------------------------------------------------------------------
    // Starvation count
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (switchNow || otherDeeper) begin
            // New owner or a deeper rival restarts the count
            cnt <= '0;
        end else if (servedLast && !limitHit) begin
            // Holds at the limit until a switch
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* memCtrlTop.f */
+incdir+logic
logic/memCtrlPkg.sv
logic/chanRespIf.sv
logic/readQueue.sv
logic/channelStore.sv
logic/serveCounter.sv
logic/respArbiter.sv
logic/memCtrlTop.sv
sim/memCtrlTop_chk.sv
sim/memCtrlTop_tb.sv

/* run.sh */
#!/bin/sh
# Compile the memCtrlTop testbench with Verilator and run it
# Only the pass banner in the log counts as success

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f memCtrlTop.f \
    --top-module memCtrlTop_tb -o memCtrlTop_sim \
    && ./obj_dir/memCtrlTop_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q '\*\*\* TEST PASSED \*\*\*' sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* sim/memCtrlTop_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memCtrl_macros.svh"

module memCtrlTop_chk (
    input logic clk,
    input logic rst_n,
    input logic reqValid,
    input logic reqWrite,
    input logic respValid,
    input logic respLast,
    input logic ackValid,
    input logic grant0,
    input logic grant1
);
    // Beats already seen in the current burst
    int beatCnt;
    // Failed assertions, summed up by the testbench
    int assertFails = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beatCnt <= 0;
        end else if (respValid) begin
            beatCnt <= respLast ? 0 : beatCnt + 1;
        end
    end

    // ------------------------------------------------------------------
    // Response protocol
    // ------------------------------------------------------------------

    lastNeedsValid: assert property (@(posedge clk) disable iff (!rst_n)
        respLast |-> respValid)
        else begin assertFails++; $error("respLast seen without respValid"); end

    // Last beat lands exactly on the burst length
    burstLength: assert property (@(posedge clk) disable iff (!rst_n)
        respValid |-> (respLast == (beatCnt == `MC_BURST_LEN - 1)))
        else begin assertFails++; $error("Burst length differs from MC_BURST_LEN"); end

    burstGapless: assert property (@(posedge clk) disable iff (!rst_n)
        respValid && !respLast |=> respValid)
        else begin assertFails++; $error("Gap inside a burst"); end

    oneGrant: assert property (@(posedge clk) disable iff (!rst_n)
        !(grant0 && grant1))
        else begin assertFails++; $error("Both channels granted"); end

    // Ack one cycle after a write and never otherwise
    ackAfterWrite: assert property (@(posedge clk) disable iff (!rst_n)
        reqValid && reqWrite |=> ackValid)
        else begin assertFails++; $error("Write not acked one cycle later"); end

    ackOnlyAfterWrite: assert property (@(posedge clk) disable iff (!rst_n)
        ackValid |-> $past(reqValid && reqWrite))
        else begin assertFails++; $error("Ack without a write one cycle before"); end

endmodule

bind memCtrlTop memCtrlTop_chk i_chk (
    .clk (clk), .rst_n (rst_n),
    .reqValid (reqValid), .reqWrite (reqWrite),
    .respValid (respValid), .respLast (respLast), .ackValid (ackValid),
    .grant0 (ch0Resp.grant), .grant1 (ch1Resp.grant)
);

`default_nettype wire

/* sim/memCtrlTop_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memCtrl_macros.svh"

module memCtrlTop_tb import memCtrlPkg::*; ();

    localparam int NumStim  = 30;
    localparam int NumWords = 1 << `MC_WORD_ADDR_W;
    localparam int Timeout  = NumStim * 40 + 200;

    // One table row holds write flag, address, id, data and idle cycles after it
    typedef struct packed {
        logic       write;
        memAddr_t   addr;
        reqId_t     id;
        dataWord_t  data;
        logic [3:0] gap;
    } stim_t;

    // Read still waiting for its first beat
    typedef struct packed {
        wordAddr_t addr;
        reqId_t    id;
    } pendRead_t;

    logic       clk;
    logic       rst_n;
    logic       reqValid;
    logic       reqWrite;
    memAddr_t   reqAddr;
    reqId_t     reqId;
    dataWord_t  reqData;
    logic       respValid;
    logic       respLast;
    dataWord_t  respData;
    reqId_t     respId;
    logic       ackValid;
    reqId_t     ackId;
    logic [1:0] chFull;

    // Reference model
    stim_t      stimTable [NumStim];
    dataWord_t  shadow [2][NumWords];
    pendRead_t  pend0 [$];
    pendRead_t  pend1 [$];
    pendRead_t  burstReq;
    int         burstCh;
    int         beatNum = 0;
    int         waitBursts [2] = '{0, 0};
    logic [1:0] sawFull = 2'b00;
    int         cycle = 0;
    int         wrCycle = -10;
    reqId_t     wrId;
    int         errors = 0;
    int         checks = 0;
    integer     seed;

    memCtrlTop i_memCtrlTop (
        .clk (clk), .rst_n (rst_n),
        .reqValid (reqValid), .reqWrite (reqWrite), .reqAddr (reqAddr),
        .reqId (reqId), .reqData (reqData),
        .respValid (respValid), .respLast (respLast),
        .respData (respData), .respId (respId),
        .ackValid (ackValid), .ackId (ackId), .chFull (chFull)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    task automatic noteFailure(input string what);
        errors++;
        $display("t=%0t: %s", $time, what);
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic sendReq(input stim_t s);
        int        ch;
        pendRead_t p;
        ch = int'(s.addr[`MC_WORD_ADDR_W]);
        // Hold the request back while the target queue is full
        while (chFull[ch]) begin
            @(posedge clk);
            #1;
        end
        reqValid = 1'b1;
        reqWrite = s.write;
        reqAddr  = s.addr;
        reqId    = s.id;
        reqData  = s.data;
        @(posedge clk);
        // The model moves with the DUT at the sampling edge
        if (s.write) begin
            shadow[ch][s.addr[`MC_WORD_ADDR_W-1:0]] = s.data;
            wrCycle = cycle;
            wrId    = s.id;
        end else begin
            p.addr = s.addr[`MC_WORD_ADDR_W-1:0];
            p.id   = s.id;
            if (ch == 0) begin
                pend0.push_back(p);
            end else begin
                pend1.push_back(p);
            end
        end
        #1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        repeat (s.gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ------------------------------------------------------------------
    // Monitors sampled mid-cycle
    // ------------------------------------------------------------------

    // Ack due in the cycle right after the write edge
    always @(negedge clk) begin
        if (rst_n) begin
            checkEq("ackValid", ackValid, wrCycle == cycle);
            if (wrCycle == cycle) begin
                checkEq("ackId", ackId, wrId);
            end
        end
        cycle++;
    end

    always @(negedge clk) begin : beatMonitor
        dataWord_t expData;
        int        other;
        if (rst_n && respValid) begin
            if (beatNum == 0) begin
                // Burst owner found from the head ids since ch0 and ch1 ids never overlap
                if (pend0.size() > 0 && pend0[0].id == respId) begin
                    burstCh  = 0;
                    burstReq = pend0.pop_front();
                end else if (pend1.size() > 0 && pend1[0].id == respId) begin
                    burstCh  = 1;
                    burstReq = pend1.pop_front();
                end else begin
                    burstCh = -1;
                    noteFailure("Response id matches no pending read");
                end
                if (burstCh >= 0) begin
                    waitBursts[burstCh] = 0;
                end
            end
            if (burstCh >= 0) begin
                // Beat k reads start address plus k and wraps in the channel
                expData = shadow[burstCh][(int'(burstReq.addr) + beatNum) % NumWords];
                checkEq("respData", respData, expData);
                checkEq("respId", respId, burstReq.id);
            end
            checkEq("respLast", respLast, beatNum == `MC_BURST_LEN - 1);
            if (beatNum == `MC_BURST_LEN - 1) begin
                beatNum = 0;
                if (burstCh >= 0) begin
                    other = 1 - burstCh;
                    if ((other == 0 && pend0.size() > 0) || (other == 1 && pend1.size() > 0)) begin
                        waitBursts[other]++;
                        if (waitBursts[other] > `MC_SERVE_LIMIT) begin
                            noteFailure("Waiting channel starved beyond the serve limit");
                        end
                    end
                end
            end else begin
                beatNum++;
            end
        end else if (rst_n && beatNum != 0) begin
            noteFailure("Burst stopped before its last beat");
            beatNum = 0;
        end
    end

    // Full needs at least a queue's worth of reads not yet started
    always @(negedge clk) begin
        if (rst_n) begin
            if (chFull[0]) begin
                sawFull[0] = 1'b1;
                if (pend0.size() < `MC_QUEUE_DEPTH) begin
                    noteFailure("Channel 0 reports full with too few reads pending");
                end
            end
            if (chFull[1]) begin
                sawFull[1] = 1'b1;
                if (pend1.size() < `MC_QUEUE_DEPTH) begin
                    noteFailure("Channel 1 reports full with too few reads pending");
                end
            end
        end
    end

    // Stop runaway runs
    initial begin
        repeat (Timeout) @(posedge clk);
        $display("Watchdog expired after %0d cycles with reads still outstanding", Timeout);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    initial begin : mainSeq
        stim_t s;
        int    i;
        seed     = 32'hbdcc;
        rst_n    = 1'b0;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr  = '0;
        reqId    = '0;
        reqData  = '0;
        // Columns are write, addr, id, data and gap
        // Ch0 reads use ids 0 to 7 and ch1 reads use 8 to 15
        stimTable = '{
            // Known words acked one cycle later
            '{1'b1, 5'h02, 4'h1, 32'hcafe_0002, 4'd0},
            '{1'b1, 5'h15, 4'h9, 32'hbeef_0015, 4'd1},
            '{1'b1, 5'h0e, 4'h2, 32'h1234_000e, 4'd0},
            '{1'b1, 5'h1f, 4'ha, 32'h5678_001f, 4'd2},
            // Reads to both channels where two of them wrap
            '{1'b0, 5'h02, 4'h1, 32'h0, 4'd0},
            '{1'b0, 5'h15, 4'h9, 32'h0, 4'd0},
            '{1'b0, 5'h0e, 4'h2, 32'h0, 4'd0},
            '{1'b0, 5'h1f, 4'ha, 32'h0, 4'd15},
            // ch0 kept full while one ch1 read waits
            '{1'b0, 5'h00, 4'h3, 32'h0, 4'd0},
            '{1'b0, 5'h04, 4'h4, 32'h0, 4'd0},
            '{1'b0, 5'h08, 4'h5, 32'h0, 4'd0},
            '{1'b0, 5'h0c, 4'h6, 32'h0, 4'd0},
            '{1'b0, 5'h03, 4'h7, 32'h0, 4'd0},
            '{1'b0, 5'h18, 4'hb, 32'h0, 4'd0},
            '{1'b0, 5'h01, 4'h0, 32'h0, 4'd0},
            '{1'b0, 5'h05, 4'h1, 32'h0, 4'd0},
            '{1'b0, 5'h09, 4'h2, 32'h0, 4'd0},
            '{1'b0, 5'h0d, 4'h3, 32'h0, 4'd0},
            '{1'b0, 5'h06, 4'h4, 32'h0, 4'd0},
            '{1'b0, 5'h0a, 4'h5, 32'h0, 4'd15},
            // Back to back ch1 reads fill its queue
            '{1'b0, 5'h10, 4'hc, 32'h0, 4'd0},
            '{1'b0, 5'h13, 4'hd, 32'h0, 4'd0},
            '{1'b0, 5'h16, 4'he, 32'h0, 4'd0},
            '{1'b0, 5'h19, 4'hf, 32'h0, 4'd0},
            '{1'b0, 5'h1c, 4'h8, 32'h0, 4'd0},
            '{1'b0, 5'h11, 4'h9, 32'h0, 4'd15},
            // Write then read back the same word
            '{1'b1, 5'h07, 4'h3, 32'ha5a5_0007, 4'd0},
            '{1'b0, 5'h07, 4'h4, 32'h0, 4'd0},
            '{1'b1, 5'h17, 4'hc, 32'h5a5a_0017, 4'd0},
            '{1'b0, 5'h17, 4'hd, 32'h0, 4'd8}
        };
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Random fill of every word of both channels
        for (i = 0; i < 2 * NumWords; i++) begin
            s.write = 1'b1;
            s.addr  = memAddr_t'(i);
            s.id    = reqId_t'(i);
            s.data  = $random(seed);
            s.gap   = 4'd0;
            sendReq(s);
        end
        for (i = 0; i < NumStim; i++) begin
            sendReq(stimTable[i]);
        end
        while (pend0.size() != 0 || pend1.size() != 0 || beatNum != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        checkEq("chFull", chFull, 2'b00);
        checkEq("sawFull", sawFull, 2'b11);
        errors = errors + i_memCtrlTop.i_chk.assertFails;
        $display("Run complete: %0d checks, %0d errors (%0d from assertions)",
            checks, errors, i_memCtrlTop.i_chk.assertFails);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
